// File: Makefile
VERILATOR ?= verilator
TOP       ?= coreTb
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
rtl/mipsPkg.sv
rtl/ctrlIf.sv
rtl/controller.sv
rtl/regFile.sv
rtl/alu.sv
rtl/loadStoreUnit.sv
rtl/pcUnit.sv
rtl/mipsCore.sv
sim/tbAsmPkg.sv
sim/coreTb.sv

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic [mipsPkg::dataWidth-1:0] opA,
  input  logic [mipsPkg::dataWidth-1:0] opB,
  input  logic [4:0]                    shamt,
  input  mipsPkg::functT                funct,
  ctrlIf.sink                           ctl,
  output logic [mipsPkg::dataWidth-1:0] result,
  output logic                          condTrue
);
  import mipsPkg::*;

  logic signedLt; // signed opA < opB
  logic aNeg;
  logic aZero;

  assign signedLt = $signed(opA) < $signed(opB);
  assign aNeg     = opA[dataWidth-1];
  assign aZero    = (opA == '0);

  //////////////////////////////
  // result path
  //////////////////////////////
  always_comb begin
    result = '0;
    case (ctl.aluOp)
      aluAdd, aluAddI: result = opA + opB;
      aluAnd:          result = opA & opB;
      aluOr:           result = opA | opB;
      aluXor:          result = opA ^ opB;
      aluSlt:          result = {{(dataWidth-1){1'b0}}, signedLt};
      aluMul:          result = opA * opB; // low word only
      aluPass:         result = opA;
      aluFunct: begin
        case (funct)
          fnAdd:   result = opA + opB;
          fnSub:   result = opA - opB;
          fnAnd:   result = opA & opB;
          fnOr:    result = opA | opB;
          fnXor:   result = opA ^ opB;
          fnSlt:   result = {{(dataWidth-1){1'b0}}, signedLt};
          fnSll:   result = opB << shamt; // shifts act on rt
          fnSrl:   result = opB >> shamt;
          default: result = '0;
        endcase
      end
      default: result = '0; // compares give no result
    endcase
  end

  //////////////////////////////
  // branch compare
  //////////////////////////////
  always_comb begin
    case (ctl.aluOp)
      aluEq:   condTrue = (opA == opB);
      aluNe:   condTrue = (opA != opB);
      aluGez:  condTrue = !aNeg;
      aluGtz:  condTrue = !aNeg && !aZero;
      aluLez:  condTrue = aNeg || aZero;
      aluLtz:  condTrue = aNeg;
      default: condTrue = 1'b0;
    endcase
  end

endmodule

// File: rtl/controller.sv
`timescale 1ns/1ps

module controller (
  input  mipsPkg::opcodeT              opcode,
  input  mipsPkg::functT               funct,
  input  logic [4:0]                   regImm,    // rt field
  input  logic [mipsPkg::dataWidth-1:0] instrWord,
  ctrlIf.decoder                       ctl,
  output logic                         issue
);
  import mipsPkg::*;

  always_comb begin
    // everything inactive unless the opcode says otherwise
    ctl.regDst     = 1'b0;
    ctl.memRead    = 1'b0;
    ctl.memToReg   = 1'b0;
    ctl.aluOp      = aluAdd;
    ctl.memWrite   = 1'b0;
    ctl.aluSrc     = 1'b0;
    ctl.regWrite   = 1'b0;
    ctl.branchType = brNone;
    ctl.jal        = 1'b0;

    case (opcode)
      opRType: begin
        if (funct == fnJr) begin
          ctl.aluOp      = aluPass;
          ctl.branchType = brReg; // no register write
        end else begin
          ctl.regDst   = 1'b1;
          ctl.aluOp    = aluFunct;
          ctl.regWrite = 1'b1;
        end
      end
      opMul: begin
        ctl.regDst   = 1'b1;
        ctl.aluOp    = aluMul;
        ctl.regWrite = 1'b1;
      end

      //////////////////////////////
      // immediate arithmetic
      //////////////////////////////
      opAddi, opAndi, opOri, opXori, opSlti: begin
        ctl.aluSrc   = 1'b1;
        ctl.regWrite = 1'b1;
        case (opcode)
          opAndi:  ctl.aluOp = aluAnd;
          opOri:   ctl.aluOp = aluOr;
          opXori:  ctl.aluOp = aluXor;
          opSlti:  ctl.aluOp = aluSlt;
          default: ctl.aluOp = aluAddI;
        endcase
      end

      //////////////////////////////
      // memory
      //////////////////////////////
      opLw, opLh, opLb: begin
        ctl.memRead  = 1'b1;
        ctl.memToReg = 1'b1;
        ctl.aluSrc   = 1'b1; // base + offset
        ctl.regWrite = 1'b1;
      end
      opSw, opSh, opSb: begin
        ctl.memWrite = 1'b1;
        ctl.aluSrc   = 1'b1;
      end

      //////////////////////////////
      // branches and jumps
      //////////////////////////////
      opRegImm: begin
        if (regImm == 5'b00001) begin // bgez
          ctl.aluOp      = aluGez;
          ctl.branchType = brCond;
        end else if (regImm == 5'b00000) begin // bltz
          ctl.aluOp      = aluLtz;
          ctl.branchType = brCond;
        end
      end
      opBeq, opBne, opBgtz, opBlez: begin
        ctl.branchType = brCond;
        case (opcode)
          opBeq:   ctl.aluOp = aluEq;
          opBne:   ctl.aluOp = aluNe;
          opBgtz:  ctl.aluOp = aluGtz;
          default: ctl.aluOp = aluLez;
        endcase
      end
      opJ: begin
        ctl.aluOp      = aluPass;
        ctl.branchType = brJump;
      end
      opJal: begin
        ctl.aluOp      = aluPass;
        ctl.regWrite   = 1'b1; // return address to r31
        ctl.branchType = brJump;
        ctl.jal        = 1'b1;
      end
      default: ;
    endcase

    // the all-zero word is a no-op, not sll r0
    issue = (instrWord != '0);
    if (!issue) begin
      ctl.regDst     = 1'b0;
      ctl.memRead    = 1'b0;
      ctl.memToReg   = 1'b0;
      ctl.aluOp      = aluAdd;
      ctl.memWrite   = 1'b0;
      ctl.aluSrc     = 1'b0;
      ctl.regWrite   = 1'b0;
      ctl.branchType = brNone;
      ctl.jal        = 1'b0;
    end
  end

endmodule

// File: rtl/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf;
  import mipsPkg::*;

  logic   regDst;     // write rd instead of rt
  logic   memRead;    // load
  logic   memToReg;   // writeback from memory
  aluOpT  aluOp;
  logic   memWrite;   // store
  logic   aluSrc;     // second operand is the immediate
  logic   regWrite;
  branchT branchType;
  logic   jal;        // link into r31

  modport decoder (
    output regDst, memRead, memToReg, aluOp, memWrite,
    output aluSrc, regWrite, branchType, jal
  );

  modport sink (
    input regDst, memRead, memToReg, aluOp, memWrite,
    input aluSrc, regWrite, branchType, jal
  );

endinterface

// File: rtl/loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit (
  input  logic                          rstN,
  input  mipsPkg::opcodeT               opcode,
  input  logic [mipsPkg::dataWidth-1:0] addr,      // byte address from the alu
  input  logic [mipsPkg::dataWidth-1:0] storeData, // rt value
  input  logic [mipsPkg::dataWidth-1:0] rdata,
  ctrlIf.sink                           ctl,
  output logic [mipsPkg::dataWidth-1:0] memAddr,
  output logic [mipsPkg::dataWidth-1:0] memWdata,
  output logic [3:0]                    memByteEn,
  output logic                          memWrite,
  output logic                          memRead,
  output logic [mipsPkg::dataWidth-1:0] loadData
);
  import mipsPkg::*;

  logic [7:0]  loadByte;
  logic [15:0] loadHalf;

  assign memAddr  = {addr[dataWidth-1:2], 2'b00};
  assign memWrite = ctl.memWrite && rstN; // quiet while in reset
  assign memRead  = ctl.memRead && rstN;

  //////////////////////////////
  // store lanes
  //////////////////////////////
  always_comb begin
    memWdata  = storeData;
    memByteEn = 4'b0000;
    case (opcode)
      opSb: begin
        memWdata  = {4{storeData[7:0]}};
        memByteEn = 4'b0001 << addr[1:0];
      end
      opSh: begin
        memWdata  = {2{storeData[15:0]}};
        memByteEn = addr[1] ? 4'b1100 : 4'b0011;
      end
      opSw: memByteEn = 4'b1111;
      default: ;
    endcase
  end

  //////////////////////////////
  // load extract
  //////////////////////////////
  assign loadByte = rdata[{addr[1:0], 3'b000} +: 8]; // little endian lanes
  assign loadHalf = addr[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (opcode)
      opLb:    loadData = {{(dataWidth-8){loadByte[7]}}, loadByte};
      opLh:    loadData = {{(dataWidth-16){loadHalf[15]}}, loadHalf};
      default: loadData = rdata; // lw
    endcase
  end

endmodule

// File: rtl/mipsCore.sv
`timescale 1ns/1ps

module mipsCore #(
  parameter logic [mipsPkg::dataWidth-1:0] resetAddr = '0
) (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic [mipsPkg::dataWidth-1:0] instr,
  output logic [mipsPkg::dataWidth-1:0] pc,
  output logic [mipsPkg::dataWidth-1:0] memAddr,
  output logic [mipsPkg::dataWidth-1:0] memWdata,
  output logic [3:0]                    memByteEn,
  output logic                          memWrite,
  output logic                          memRead,
  input  logic [mipsPkg::dataWidth-1:0] memRdata,
  output logic                          issue
);
  import mipsPkg::*;

  ctrlIf ctl ();

  //////////////////////////////
  // instruction fields
  //////////////////////////////
  opcodeT                opcode;
  functT                 funct;
  logic [regAddrWidth-1:0] rs;
  logic [regAddrWidth-1:0] rt;
  logic [regAddrWidth-1:0] rd;
  logic [dataWidth-1:0]  signImm;

  assign opcode  = opcodeT'(instr[31:26]);
  assign funct   = functT'(instr[5:0]);
  assign rs      = instr[25:21];
  assign rt      = instr[20:16];
  assign rd      = instr[15:11];
  assign signImm = {{16{instr[15]}}, instr[15:0]};

  logic [dataWidth-1:0]    rdataA;
  logic [dataWidth-1:0]    rdataB;
  logic [dataWidth-1:0]    aluB;
  logic [dataWidth-1:0]    aluResult;
  logic [dataWidth-1:0]    loadData;
  logic [dataWidth-1:0]    linkAddr;
  logic [dataWidth-1:0]    wbData;
  logic [regAddrWidth-1:0] writeReg;
  logic                    condTrue;

  assign aluB     = ctl.aluSrc ? signImm : rdataB;
  assign writeReg = ctl.jal ? 5'd31 : (ctl.regDst ? rd : rt);
  assign wbData   = ctl.jal ? linkAddr : (ctl.memToReg ? loadData : aluResult);

  controller i_controller (
    .opcode    (opcode),
    .funct     (funct),
    .regImm    (rt),
    .instrWord (instr),
    .ctl       (ctl),
    .issue     (issue)
  );

  regFile i_regFile (
    .clk    (clk),
    .raddrA (rs),
    .raddrB (rt),
    .waddr  (writeReg),
    .wdata  (wbData),
    .wen    (ctl.regWrite),
    .rdataA (rdataA),
    .rdataB (rdataB)
  );

  alu i_alu (
    .opA      (rdataA),
    .opB      (aluB),
    .shamt    (instr[10:6]),
    .funct    (funct),
    .ctl      (ctl),
    .result   (aluResult),
    .condTrue (condTrue)
  );

  loadStoreUnit i_loadStoreUnit (
    .rstN      (rstN),
    .opcode    (opcode),
    .addr      (aluResult),
    .storeData (rdataB),
    .rdata     (memRdata),
    .ctl       (ctl),
    .memAddr   (memAddr),
    .memWdata  (memWdata),
    .memByteEn (memByteEn),
    .memWrite  (memWrite),
    .memRead   (memRead),
    .loadData  (loadData)
  );

  pcUnit #(
    .resetAddr (resetAddr)
  ) i_pcUnit (
    .clk       (clk),
    .rstN      (rstN),
    .immOffset (signImm),
    .jumpIndex (instr[25:0]),
    .regTarget (rdataA),
    .condTrue  (condTrue),
    .ctl       (ctl),
    .pc        (pc),
    .linkAddr  (linkAddr)
  );

endmodule

// File: rtl/mipsPkg.sv
package mipsPkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int dataWidth    = 32; // machine word
  localparam int regAddrWidth = 5;  // 32 registers

  //////////////////////////////
  // instruction fields
  //////////////////////////////

  typedef enum logic [5:0] {
    opRType  = 6'b000000, // split further by funct
    opRegImm = 6'b000001, // bgez and bltz by rt
    opJ      = 6'b000010,
    opJal    = 6'b000011,
    opBeq    = 6'b000100,
    opBne    = 6'b000101,
    opBlez   = 6'b000110,
    opBgtz   = 6'b000111,
    opAddi   = 6'b001000,
    opSlti   = 6'b001010,
    opAndi   = 6'b001100,
    opOri    = 6'b001101,
    opXori   = 6'b001110,
    opMul    = 6'b011100, // SPECIAL2
    opLb     = 6'b100000,
    opLh     = 6'b100001,
    opLw     = 6'b100011,
    opSb     = 6'b101000,
    opSh     = 6'b101001,
    opSw     = 6'b101011
  } opcodeT;

  typedef enum logic [5:0] {
    fnSll = 6'b000000,
    fnSrl = 6'b000010,
    fnJr  = 6'b001000,
    fnMul = 6'b011000, // mul itself decodes by opcode
    fnAdd = 6'b100000,
    fnSub = 6'b100010,
    fnAnd = 6'b100100,
    fnOr  = 6'b100101,
    fnXor = 6'b100110,
    fnSlt = 6'b101010
  } functT;

  //////////////////////////////
  // control encodings
  //////////////////////////////

  typedef enum logic [3:0] {
    aluAdd   = 4'b0000, // address calc
    aluAddI  = 4'b0001,
    aluFunct = 4'b0010, // resolved by funct
    aluGez   = 4'b0011,
    aluEq    = 4'b0100,
    aluNe    = 4'b0101,
    aluGtz   = 4'b0110,
    aluLez   = 4'b0111,
    aluLtz   = 4'b1000,
    aluPass  = 4'b1001,
    aluAnd   = 4'b1010,
    aluOr    = 4'b1011,
    aluXor   = 4'b1100,
    aluSlt   = 4'b1101,
    aluMul   = 4'b1111
  } aluOpT;

  typedef enum logic [1:0] {
    brNone = 2'd0, // pc + 4
    brJump = 2'd1, // j / jal
    brReg  = 2'd2, // jr
    brCond = 2'd3  // taken on condTrue
  } branchT;

endpackage

// File: rtl/pcUnit.sv
`timescale 1ns/1ps

module pcUnit #(
  parameter logic [mipsPkg::dataWidth-1:0] resetAddr = '0
) (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic [mipsPkg::dataWidth-1:0] immOffset, // sign-extended, in words
  input  logic [25:0]                   jumpIndex,
  input  logic [mipsPkg::dataWidth-1:0] regTarget, // rs for jr
  input  logic                          condTrue,
  ctrlIf.sink                           ctl,
  output logic [mipsPkg::dataWidth-1:0] pc,
  output logic [mipsPkg::dataWidth-1:0] linkAddr
);
  import mipsPkg::*;

  logic [dataWidth-1:0] pcPlus4;
  logic [dataWidth-1:0] branchTarget;
  logic [dataWidth-1:0] nextPc;

  assign pcPlus4      = pc + 32'd4;
  assign branchTarget = pcPlus4 + {immOffset[dataWidth-3:0], 2'b00};
  assign linkAddr     = pcPlus4;

  always_comb begin
    case (ctl.branchType)
      brJump:  nextPc = {pcPlus4[dataWidth-1:28], jumpIndex, 2'b00}; // same 256MB region
      brReg:   nextPc = regTarget;
      brCond:  nextPc = condTrue ? branchTarget : pcPlus4;
      default: nextPc = pcPlus4;
    endcase
  end

  //////////////////////////////
  // pc register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= resetAddr;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic                             clk,
  input  logic [mipsPkg::regAddrWidth-1:0] raddrA,
  input  logic [mipsPkg::regAddrWidth-1:0] raddrB,
  input  logic [mipsPkg::regAddrWidth-1:0] waddr,
  input  logic [mipsPkg::dataWidth-1:0]    wdata,
  input  logic                             wen,
  output logic [mipsPkg::dataWidth-1:0]    rdataA,
  output logic [mipsPkg::dataWidth-1:0]    rdataB
);
  import mipsPkg::*;

  localparam int numRegs = 2 ** regAddrWidth;

  logic [dataWidth-1:0] regs [numRegs];

  always_ff @(posedge clk) begin
    if (wen) begin
      regs[waddr] <= wdata; // r0 write lands but is never seen
    end
  end

  // reads see the value from before this edge
  assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
  assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

endmodule

// File: sim/coreTb.sv
`timescale 1ns/1ps

module coreTb;
  import mipsPkg::*;
  import tbAsmPkg::*;

  localparam logic [31:0] resetAddr = 32'h0000_0100;
  localparam logic [31:0] sentinel  = 32'h0000_03fc; // store here ends a program
  localparam int imemWords = 128;
  localparam int dmemWords = 256;
  localparam int numTests  = 6;
  localparam int maxCycles = 300;

  logic        clk;
  logic        rstN;
  logic [31:0] instr;
  logic [31:0] pc;
  logic [31:0] memAddr;
  logic [31:0] memWdata;
  logic [3:0]  memByteEn;
  logic        memWrite;
  logic        memRead;
  logic [31:0] memRdata;
  logic        issue;

  logic [31:0] imem [imemWords];
  logic [31:0] dmem [dmemWords];
  int          progLen;
  int          errors;
  int          failedTests;
  logic [31:0] storeAddr [$];
  logic [31:0] storeData [$];
  logic [3:0]  storeEn [$];

  mipsCore #(
    .resetAddr (resetAddr)
  ) i_dut (
    .clk       (clk),
    .rstN      (rstN),
    .instr     (instr),
    .pc        (pc),
    .memAddr   (memAddr),
    .memWdata  (memWdata),
    .memByteEn (memByteEn),
    .memWrite  (memWrite),
    .memRead   (memRead),
    .memRdata  (memRdata),
    .issue     (issue)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  assign memRdata = dmem[memAddr[9:2]]; // combinational read

  //////////////////////////////
  // compare tasks
  //////////////////////////////
  task automatic checkWord(logic [dataWidth-1:0] got, logic [dataWidth-1:0] exp, string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic checkEnables(logic [3:0] got, logic [3:0] exp, string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic checkFlag(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic expectStore(int idx, logic [31:0] addr, logic [31:0] data, logic [3:0] en,
                             string what);
    if (idx >= storeAddr.size()) begin
      $display("store number %0d (%s) never happened", idx, what);
      errors++;
    end else begin
      checkWord(storeAddr[idx], addr, {what, " address"});
      checkWord(storeData[idx], data, {what, " data"});
      checkEnables(storeEn[idx], en, {what, " enables"});
    end
  endtask

  //////////////////////////////
  // program and run helpers
  //////////////////////////////
  function automatic logic [31:0] fetchWord(logic [31:0] pcVal);
    int idx;
    if (pcVal < resetAddr) return 32'h0;
    idx = int'((pcVal - resetAddr) >> 2);
    return (idx < progLen) ? imem[idx] : 32'h0; // past the end reads as no-op
  endfunction

  task automatic emit(logic [31:0] word);
    imem[progLen] = word;
    progLen++;
  endtask

  task automatic clearProgram();
    progLen = 0;
    storeAddr.delete();
    storeData.delete();
    storeEn.delete();
    for (int i = 0; i < dmemWords; i++) begin
      dmem[i] = 32'h9e37_79b9 * (i + 1); // differs for every word
    end
  endtask

  task automatic resetCore(logic [31:0] resetInstr);
    @(negedge clk);
    rstN  = 1'b0;
    instr = resetInstr;
    repeat (8) begin
      @(posedge clk);
      checkFlag(memWrite, 1'b0, "memWrite in reset");
      checkFlag(memRead, 1'b0, "memRead in reset");
    end
    @(negedge clk);
    rstN = 1'b1;
    checkWord(pc, resetAddr, "first pc");
    instr = fetchWord(pc);
  endtask

  task automatic runProgram();
    int   cycles;
    logic done;
    logic isLoad;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < maxCycles) begin
      @(posedge clk);
      isLoad = (instr[31:26] == opLb) || (instr[31:26] == opLh) || (instr[31:26] == opLw);
      checkFlag(issue, instr != 32'h0, "issue");
      checkFlag(memRead, isLoad, "memRead");
      if (memWrite) begin
        for (int b = 0; b < 4; b++) begin
          if (memByteEn[b]) dmem[memAddr[9:2]][8*b +: 8] = memWdata[8*b +: 8];
        end
        storeAddr.push_back(memAddr);
        storeData.push_back(memWdata);
        storeEn.push_back(memByteEn);
        done = (memAddr == sentinel);
      end
      @(negedge clk);
      instr = fetchWord(pc);
      cycles++;
    end
    if (!done) begin
      $display("program did not reach its final store within %0d cycles", maxCycles);
      errors++;
    end
  endtask

  task automatic reportTest(string name, int errBefore);
    if (errors == errBefore) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errBefore);
      failedTests++;
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////
  task automatic testAlu();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp [numRefOps];
    int          imm;
    int          sh;
    int          errBefore;
    refOpT       curOp;
    errBefore = errors;
    clearProgram();
    a = $urandom();
    b = $urandom();
    dmem[0] = a;
    dmem[1] = b;
    emit(encI(opLw, 0, 1, 0));
    emit(encI(opLw, 0, 2, 4));
    for (int k = 0; k < numRefOps; k++) begin
      imm    = int'($urandom() & 32'hffff);
      sh     = int'($urandom() % 32);
      exp[k] = refResult(refOpT'(k), a, b, imm, sh);
      emit(encOp(refOpT'(k), 1, 2, 3, imm, sh));
      emit(encI(opSw, 0, 3, 32'h20 + 4 * k));
    end
    emit(encI(opSw, 0, 0, sentinel));
    resetCore(32'h0);
    runProgram();
    for (int k = 0; k < numRefOps; k++) begin
      curOp = refOpT'(k);
      expectStore(k, 32'h20 + 4 * k, exp[k], 4'b1111, curOp.name());
    end
    reportTest("alu", errBefore);
  endtask

  task automatic testLoadStore();
    logic [31:0] v;
    int          errBefore;
    errBefore = errors;
    clearProgram();
    v       = $urandom() | 32'h8080_8080; // negative byte and half
    dmem[0] = v;
    emit(encI(opLw, 0, 1, 0));
    emit(encI(opSb, 0, 1, 32'h41));
    emit(encI(opSh, 0, 1, 32'h46));
    emit(encI(opSw, 0, 1, 32'h48));
    emit(encI(opLb, 0, 4, 32'h41));
    emit(encI(opLh, 0, 5, 32'h46));
    emit(encI(opLw, 0, 6, 32'h48));
    emit(encI(opSw, 0, 4, 32'h80));
    emit(encI(opSw, 0, 5, 32'h84));
    emit(encI(opSw, 0, 6, 32'h88));
    emit(encI(opSw, 0, 0, sentinel));
    resetCore(32'h0);
    runProgram();
    expectStore(0, 32'h40, {4{v[7:0]}}, 4'b0010, "sb");
    expectStore(1, 32'h44, {2{v[15:0]}}, 4'b1100, "sh");
    expectStore(2, 32'h48, v, 4'b1111, "sw");
    expectStore(3, 32'h80, {{24{v[7]}}, v[7:0]}, 4'b1111, "lb");
    expectStore(4, 32'h84, {{16{v[15]}}, v[15:0]}, 4'b1111, "lh");
    expectStore(5, 32'h88, v, 4'b1111, "lw");
    reportTest("load store", errBefore);
  endtask

  task automatic testBranches();
    logic [31:0] regVal [4];
    logic [31:0] takenMark;
    logic [31:0] fallMark;
    opcodeT      singleOp [4];
    int          singleRt [4];
    opcodeT      op [16];
    int          rs [16];
    int          rt [16];
    logic        taken;
    int          errBefore;
    errBefore = errors;
    clearProgram();
    regVal    = '{32'h0, 32'h0, ($urandom() & 32'h7fff_ffff) | 32'h1, $urandom() | 32'h8000_0000};
    takenMark = 32'h7a4e_0001;
    fallMark  = 32'h0f0f_0002;
    singleOp  = '{opBgtz, opBlez, opRegImm, opRegImm};
    singleRt  = '{0, 0, 1, 0}; // bgez, then bltz
    dmem[0] = regVal[2];
    dmem[1] = regVal[3];
    dmem[2] = takenMark;
    dmem[3] = fallMark;
    for (int k = 0; k < 4; k++) begin
      op[k] = (k < 2) ? opBeq : opBne;
      rs[k] = 2;
      rt[k] = (k % 2 == 0) ? 2 : 3;
    end
    for (int k = 4; k < 16; k++) begin
      op[k] = singleOp[(k - 4) / 3];
      rt[k] = singleRt[(k - 4) / 3];
      rs[k] = ((k - 4) % 3 == 0) ? 0 : ((k - 4) % 3 + 1); // zero, positive, negative
    end
    emit(encI(opLw, 0, 2, 0));
    emit(encI(opLw, 0, 3, 4));
    emit(encI(opLw, 0, 4, 8));
    emit(encI(opLw, 0, 5, 12));
    for (int k = 0; k < 16; k++) begin
      emit(encI(op[k], rs[k], rt[k], 2)); // taken lands on the taken marker
      emit(encI(opSw, 0, 5, 32'h40 + 4 * k));
      emit(encI(opBeq, 0, 0, 1));
      emit(encI(opSw, 0, 4, 32'h40 + 4 * k));
    end
    emit(encI(opSw, 0, 0, sentinel));
    resetCore(32'h0);
    runProgram();
    for (int k = 0; k < 16; k++) begin
      taken = branchTaken(op[k], rt[k], regVal[rs[k]], (op[k] == opBeq || op[k] == opBne) ?
                          regVal[rt[k]] : 32'h0);
      expectStore(k, 32'h40 + 4 * k, taken ? takenMark : fallMark, 4'b1111, op[k].name());
    end
    checkWord(storeAddr.size(), 17, "branch store count");
    reportTest("branches", errBefore);
  endtask

  task automatic testJumps();
    int errBefore;
    errBefore = errors;
    clearProgram();
    dmem[0] = 32'h0000_aaaa;
    dmem[1] = 32'h0000_bbbb;
    emit(encI(opLw, 0, 4, 0));
    emit(encI(opLw, 0, 5, 4));
    emit(encJ(opJ, resetAddr + 16));    // over the next store
    emit(encI(opSw, 0, 5, 32'h100));
    emit(encJ(opJal, resetAddr + 32));  // call
    emit(encI(opSw, 0, 31, 32'h104));   // return lands here
    emit(encI(opSw, 0, 5, 32'h108));
    emit(encJ(opJ, resetAddr + 44));
    emit(encI(opSw, 0, 4, 32'h10c));    // callee
    emit(encR(fnJr, 31, 0, 0, 0));
    emit(encI(opSw, 0, 5, 32'h10c));
    emit(encI(opSw, 0, 0, sentinel));
    resetCore(32'h0);
    runProgram();
    expectStore(0, 32'h10c, 32'h0000_aaaa, 4'b1111, "callee marker");
    expectStore(1, 32'h104, resetAddr + 20, 4'b1111, "link address");
    expectStore(2, 32'h108, 32'h0000_bbbb, 4'b1111, "after return");
    expectStore(3, sentinel, 32'h0, 4'b1111, "final store");
    reportTest("jumps", errBefore);
  endtask

  task automatic testNops();
    int errBefore;
    errBefore = errors;
    clearProgram();
    emit(32'h0);
    emit(32'h0);
    emit(encI(opAddi, 0, 1, 5));
    emit(32'h0);
    emit(encI(opSw, 0, 1, 32'h20));
    emit(32'h0);
    emit(encI(opSw, 0, 0, sentinel));
    resetCore(32'h0);
    runProgram();
    expectStore(0, 32'h20, 32'd5, 4'b1111, "store between no-ops");
    checkWord(storeAddr.size(), 2, "no-op store count");
    reportTest("no-ops", errBefore);
  endtask

  task automatic testReset();
    int errBefore;
    errBefore = errors;
    clearProgram();
    emit(encI(opSw, 0, 0, sentinel));
    resetCore(encI(opSw, 0, 0, 0)); // strobes must stay low anyway
    resetCore(encI(opLw, 0, 1, 0));
    runProgram();
    expectStore(0, sentinel, 32'h0, 4'b1111, "store after reset");
    reportTest("reset", errBefore);
  endtask

  //////////////////////////////
  // main and watchdog
  //////////////////////////////
  initial begin
    rstN        = 1'b0;
    instr       = 32'h0;
    errors      = 0;
    failedTests = 0;
    progLen     = 0;
    void'($urandom(32'h6e6553e1));
    testAlu();
    testLoadStore();
    testBranches();
    testJumps();
    testNops();
    testReset();
    $display("tests %0d, tests with errors %0d, errors %0d", numTests, failedTests, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(numTests * 400 * 4);
    $display("run exceeded its time limit and was stopped");
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: sim/tbAsmPkg.sv
package tbAsmPkg;
  import mipsPkg::*;

  // operations covered by the ALU test
  typedef enum int {
    rAdd, rSub, rAnd, rOr, rXor, rSlt, rSll, rSrl, rMul,
    rAddi, rAndi, rOri, rXori, rSlti
  } refOpT;

  localparam int numRefOps = 14;

  //////////////////////////////
  // encoders
  //////////////////////////////

  function automatic logic [31:0] encR(functT fn, int rs, int rt, int rd, int sh);
    return {opRType, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
  endfunction

  function automatic logic [31:0] encI(opcodeT op, int rs, int rt, int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic logic [31:0] encJ(opcodeT op, logic [31:0] target);
    return {op, target[27:2]}; // absolute word index
  endfunction

  function automatic logic [31:0] encOp(refOpT op, int rs, int rt, int rd, int imm, int sh);
    case (op)
      rAdd:    return encR(fnAdd, rs, rt, rd, 0);
      rSub:    return encR(fnSub, rs, rt, rd, 0);
      rAnd:    return encR(fnAnd, rs, rt, rd, 0);
      rOr:     return encR(fnOr, rs, rt, rd, 0);
      rXor:    return encR(fnXor, rs, rt, rd, 0);
      rSlt:    return encR(fnSlt, rs, rt, rd, 0);
      rSll:    return encR(fnSll, 0, rt, rd, sh);
      rSrl:    return encR(fnSrl, 0, rt, rd, sh);
      rMul:    return {opMul, rs[4:0], rt[4:0], rd[4:0], 5'd0, 6'b000010};
      rAddi:   return encI(opAddi, rs, rd, imm); // rt field is the destination
      rAndi:   return encI(opAndi, rs, rd, imm);
      rOri:    return encI(opOri, rs, rd, imm);
      rXori:   return encI(opXori, rs, rd, imm);
      default: return encI(opSlti, rs, rd, imm);
    endcase
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////

  // a is rs, b is rt, immediates are sign extended
  function automatic logic [31:0] refResult(refOpT op, logic [31:0] a, logic [31:0] b,
                                            int imm, int sh);
    logic [31:0] sImm;
    logic [63:0] prod;
    sImm = {{16{imm[15]}}, imm[15:0]};
    prod = a * b;
    case (op)
      rAdd:    return a + b;
      rSub:    return a - b;
      rAnd:    return a & b;
      rOr:     return a | b;
      rXor:    return a ^ b;
      rSlt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rSll:    return b << sh[4:0];
      rSrl:    return b >> sh[4:0];
      rMul:    return prod[31:0];
      rAddi:   return a + sImm;
      rAndi:   return a & sImm;
      rOri:    return a | sImm;
      rXori:   return a ^ sImm;
      default: return ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
    endcase
  endfunction

  function automatic logic branchTaken(opcodeT op, int rtField, logic [31:0] a,
                                       logic [31:0] b);
    case (op)
      opBeq:    return a == b;
      opBne:    return a != b;
      opBgtz:   return $signed(a) > 0;
      opBlez:   return $signed(a) <= 0;
      opRegImm: return (rtField == 1) ? ($signed(a) >= 0) : ($signed(a) < 0);
      default:  return 1'b0;
    endcase
  endfunction

endpackage
